// File: decode_settings.svh
`ifndef DECODE_SETTINGS_SVH
`define DECODE_SETTINGS_SVH

// Datapath widths
`define DATA_W      32
`define REG_ADDR_W  5
`define OPCODE_W    6
`define FUNCT_W     6
`define IMM_W       16

// Return address skips the delay slot
`define LINK_OFFSET 8

// Link register for BLTZAL, BGEZAL, JAL and JALR
`define REG_RA      5'd31

// Only accepted encoding of COP0 ERET
`define ERET_WORD   32'h4200_0018

`endif

// File: decode_pkg.sv
`default_nettype none
`include "decode_settings.svh"

package decode_pkg;

    typedef enum logic [5:0] {
        ALU_ADD,  ALU_ADDU,  ALU_SUB,  ALU_SUBU,
        ALU_SLT,  ALU_SLTU,  ALU_DIV,  ALU_DIVU,
        ALU_MULT, ALU_MULTU, ALU_AND,  ALU_OR,
        ALU_NOR,  ALU_XOR,   ALU_LUI,  ALU_SLL,
        ALU_SRL,  ALU_SRA,   ALU_MFHI, ALU_MFLO,
        ALU_MTHI, ALU_MTLO,  ALU_BREK, ALU_SYSC,
        ALU_ERET, ALU_MFC0,  ALU_MTC0, ALU_OUTA
    } alu_op_t;

    typedef enum logic [1:0] {
        SRC_REG = 2'd0, // rt
        SRC_IMM = 2'd1, // Extended immediate
        SRC_SFT = 2'd2, // Shift amount
        SRC_PCA = 2'd3  // Link address
    } alu_src_t;

    typedef enum logic {
        SIGN_EXTENDED = 1'b0,
        ZERO_EXTENDED = 1'b1
    } ext_t;

    typedef enum logic [1:0] {
        MEM_NOOP = 2'd0,
        MEM_LOAD = 2'd1,
        MEM_STOR = 2'd2
    } mem_type_t;

    typedef enum logic [2:0] {
        SZ_BYTE = 3'd0,
        SZ_HALF = 3'd1,
        SZ_FULL = 3'd2
    } mem_size_t;

    typedef enum logic [3:0] {
        BR_NONE, BR_BEQ, BR_BNE, BR_BLEZ, BR_BGTZ,
        BR_BLTZ, BR_BGEZ, BR_J, BR_JR
    } branch_kind_t;

    typedef struct packed {
        logic                   undefined_inst;
        alu_op_t                alu_op;
        alu_src_t               alu_src;
        ext_t                   alu_imm_src;
        mem_type_t              mem_type;
        mem_size_t              mem_size;
        logic [`REG_ADDR_W-1:0] wb_reg_dest;
        logic                   wb_reg_en;
        ext_t                   unsigned_flag;
        branch_kind_t           branch_kind;
        logic                   is_branch_al;
    } ctrl_word_t;

    typedef struct packed {
        logic [`REG_ADDR_W-1:0] rs;
        logic [`REG_ADDR_W-1:0] rt;
        logic [`REG_ADDR_W-1:0] shamt;
        logic [`DATA_W-1:0]     imm;
        logic [`DATA_W-1:0]     link_addr;
    } operand_word_t;

endpackage

`default_nettype wire

// File: branch_decoder.sv
`timescale 1ns/1ns
`default_nettype none
`include "decode_settings.svh"

module branch_decoder
    import decode_pkg::*;
(
    input  wire [`OPCODE_W-1:0]   opcode,
    input  wire [`REG_ADDR_W-1:0] rt,
    input  wire [`FUNCT_W-1:0]    funct,
    output logic                  is_branch,
    output logic                  is_branch_al,
    output branch_kind_t          branch_kind
);

    always_comb begin
        branch_kind  = BR_NONE;
        is_branch_al = 1'b0;
        case (opcode)
            6'b000100: branch_kind = BR_BEQ;
            6'b000101: branch_kind = BR_BNE;
            6'b000110: branch_kind = BR_BLEZ;
            6'b000111: branch_kind = BR_BGTZ;
            6'b000001: begin // REGIMM selects its condition by rt
                case (rt)
                    5'b00000: branch_kind = BR_BLTZ;
                    5'b00001: branch_kind = BR_BGEZ;
                    5'b10000: begin
                        branch_kind  = BR_BLTZ;
                        is_branch_al = 1'b1;
                    end
                    5'b10001: begin
                        branch_kind  = BR_BGEZ;
                        is_branch_al = 1'b1;
                    end
                    default: branch_kind = BR_NONE;
                endcase
            end
            6'b000010: branch_kind = BR_J;
            6'b000011: begin // JAL
                branch_kind  = BR_J;
                is_branch_al = 1'b1;
            end
            6'b000000: begin
                if (funct == 6'b001000) begin // JR
                    branch_kind = BR_JR;
                end else if (funct == 6'b001001) begin // JALR
                    branch_kind  = BR_JR;
                    is_branch_al = 1'b1;
                end
            end
            default: branch_kind = BR_NONE;
        endcase
    end

    assign is_branch = (branch_kind != BR_NONE);

endmodule

`default_nettype wire

// File: decoder_ctrl.sv
`timescale 1ns/1ns
`default_nettype none
`include "decode_settings.svh"

module decoder_ctrl
    import decode_pkg::*;
(
    input  wire [`DATA_W-1:0]      instruction,
    input  wire [`OPCODE_W-1:0]    opcode,
    input  wire [`REG_ADDR_W-1:0]  rt,
    input  wire [`REG_ADDR_W-1:0]  rd,
    input  wire [`FUNCT_W-1:0]     funct,
    input  wire                    is_branch,
    input  wire                    is_branch_al,
    output logic                   undefined_inst,
    output alu_op_t                alu_op,
    output alu_src_t               alu_src,
    output ext_t                   alu_imm_src,
    output mem_type_t              mem_type,
    output mem_size_t              mem_size,
    output logic [`REG_ADDR_W-1:0] wb_reg_dest,
    output logic                   wb_reg_en,
    output ext_t                   unsigned_flag  // Load result extension in MEM
);

    logic r_type;

    assign r_type = (opcode == 6'b000000);

    always_comb begin
        undefined_inst = 1'b0;
        alu_op         = ALU_ADDU;
        alu_src        = SRC_REG;
        alu_imm_src    = SIGN_EXTENDED;
        mem_type       = MEM_NOOP;
        mem_size       = SZ_FULL;
        wb_reg_dest    = rd;
        wb_reg_en      = 1'b1;
        unsigned_flag  = ZERO_EXTENDED;

        if (!r_type) begin // I-type operand and target
            alu_src     = SRC_IMM;
            wb_reg_dest = rt;
        end
        if (opcode[5:2] == 4'b0011) // ANDI ORI XORI LUI
            alu_imm_src = ZERO_EXTENDED;

        casez ({opcode, funct})
            {6'b000000, 6'b100000}: alu_op = ALU_ADD;   // ADD
            {6'b000000, 6'b100001}: alu_op = ALU_ADDU;  // ADDU
            {6'b000000, 6'b100010}: alu_op = ALU_SUB;   // SUB
            {6'b000000, 6'b100011}: alu_op = ALU_SUBU;  // SUBU
            {6'b000000, 6'b101010}: alu_op = ALU_SLT;   // SLT
            {6'b000000, 6'b101011}: alu_op = ALU_SLTU;  // SLTU
            {6'b000000, 6'b011010}: alu_op = ALU_DIV;   // DIV
            {6'b000000, 6'b011011}: alu_op = ALU_DIVU;  // DIVU
            {6'b000000, 6'b011000}: alu_op = ALU_MULT;  // MULT
            {6'b000000, 6'b011001}: alu_op = ALU_MULTU; // MULTU
            {6'b000000, 6'b100100}: alu_op = ALU_AND;   // AND
            {6'b000000, 6'b100101}: alu_op = ALU_OR;    // OR
            {6'b000000, 6'b100110}: alu_op = ALU_XOR;   // XOR
            {6'b000000, 6'b100111}: alu_op = ALU_NOR;   // NOR
            {6'b000000, 6'b000100}: alu_op = ALU_SLL;   // SLLV
            {6'b000000, 6'b000110}: alu_op = ALU_SRL;   // SRLV
            {6'b000000, 6'b000111}: alu_op = ALU_SRA;   // SRAV
            {6'b000000, 6'b010000}: alu_op = ALU_MFHI;  // MFHI
            {6'b000000, 6'b010010}: alu_op = ALU_MFLO;  // MFLO
            {6'b000000, 6'b010001}: alu_op = ALU_MTHI;  // MTHI
            {6'b000000, 6'b010011}: alu_op = ALU_MTLO;  // MTLO
            {6'b000000, 6'b001101}: alu_op = ALU_BREK;  // BREAK
            {6'b000000, 6'b001100}: alu_op = ALU_SYSC;  // SYSCALL
            {6'b000000, 6'b000000}: begin // SLL
                alu_op  = ALU_SLL;
                alu_src = SRC_SFT;
            end
            {6'b000000, 6'b000010}: begin // SRL
                alu_op  = ALU_SRL;
                alu_src = SRC_SFT;
            end
            {6'b000000, 6'b000011}: begin // SRA
                alu_op  = ALU_SRA;
                alu_src = SRC_SFT;
            end
            {6'b001000, 6'b??????}: alu_op = ALU_ADD;   // ADDI
            {6'b001001, 6'b??????}: alu_op = ALU_ADDU;  // ADDIU
            {6'b001010, 6'b??????}: alu_op = ALU_SLT;   // SLTI
            {6'b001011, 6'b??????}: alu_op = ALU_SLTU;  // SLTIU
            {6'b001100, 6'b??????}: alu_op = ALU_AND;   // ANDI
            {6'b001101, 6'b??????}: alu_op = ALU_OR;    // ORI
            {6'b001110, 6'b??????}: alu_op = ALU_XOR;   // XORI
            {6'b001111, 6'b??????}: alu_op = ALU_LUI;   // LUI
            {6'b100000, 6'b??????}: begin // LB
                mem_type      = MEM_LOAD;
                mem_size      = SZ_BYTE;
                unsigned_flag = SIGN_EXTENDED;
            end
            {6'b100100, 6'b??????}: begin // LBU
                mem_type = MEM_LOAD;
                mem_size = SZ_BYTE;
            end
            {6'b100001, 6'b??????}: begin // LH
                mem_type      = MEM_LOAD;
                mem_size      = SZ_HALF;
                unsigned_flag = SIGN_EXTENDED;
            end
            {6'b100101, 6'b??????}: begin // LHU
                mem_type = MEM_LOAD;
                mem_size = SZ_HALF;
            end
            {6'b100011, 6'b??????}: mem_type = MEM_LOAD; // LW
            {6'b101000, 6'b??????}: begin // SB
                mem_type = MEM_STOR;
                mem_size = SZ_BYTE;
            end
            {6'b101001, 6'b??????}: begin // SH
                mem_type = MEM_STOR;
                mem_size = SZ_HALF;
            end
            {6'b101011, 6'b??????}: mem_type = MEM_STOR; // SW
            {6'b010000, 6'b??????}: begin // COP0
                alu_src = SRC_REG;
                if (instruction == `ERET_WORD)
                    alu_op = ALU_ERET;
                else if (instruction[25:21] == 5'b00000)
                    alu_op = ALU_MFC0;
                else if (instruction[25:21] == 5'b00100)
                    alu_op = ALU_MTC0;
                else begin
                    undefined_inst = 1'b1;
                    wb_reg_en      = 1'b0;
                end
            end
            default: begin
                alu_src     = SRC_REG;
                wb_reg_dest = rt;
                wb_reg_en   = 1'b0;
                if (is_branch && is_branch_al) begin
                    alu_op      = ALU_OUTA; // Return address through the ALU
                    alu_src     = SRC_PCA;
                    wb_reg_dest = `REG_RA;
                    wb_reg_en   = 1'b1;
                end else begin
                    undefined_inst = ~is_branch;
                end
            end
        endcase

        // Results that land in HI/LO, CP0, a trap or memory
        if (mem_type == MEM_STOR ||
            alu_op inside {ALU_DIV, ALU_DIVU, ALU_MULT, ALU_MULTU, ALU_MTHI,
                           ALU_MTLO, ALU_BREK, ALU_SYSC, ALU_ERET, ALU_MTC0})
            wb_reg_en = 1'b0;
    end

    a_undef_no_wb: assert final (!(undefined_inst && wb_reg_en))
        else $error("undefined instruction with writeback enabled");

endmodule

`default_nettype wire

// File: imm_gen.sv
`timescale 1ns/1ns
`default_nettype none
`include "decode_settings.svh"

module imm_gen
    import decode_pkg::*;
(
    input  wire [`IMM_W-1:0]  imm16,
    input  wire [`DATA_W-1:0] pc,
    input  wire ext_t         alu_imm_src,
    input  wire alu_op_t      alu_op,
    output logic [`DATA_W-1:0] imm,
    output logic [`DATA_W-1:0] link_addr
);

    always_comb begin
        if (alu_op == ALU_LUI)
            imm = {imm16, {(`DATA_W-`IMM_W){1'b0}}}; // Upper half with zeros below
        else if (alu_imm_src == ZERO_EXTENDED)
            imm = {{(`DATA_W-`IMM_W){1'b0}}, imm16};
        else
            imm = {{(`DATA_W-`IMM_W){imm16[`IMM_W-1]}}, imm16};
    end

    assign link_addr = pc + `DATA_W'(`LINK_OFFSET);

endmodule

`default_nettype wire

// File: stage_reg.sv
`timescale 1ns/1ns
`default_nettype none

module stage_reg #(
    parameter type payload_t = logic
) (
    input  wire           clk,
    input  wire           rst,
    input  wire           in_valid,
    input  wire           stall,
    input  wire           flush,
    input  wire payload_t d,
    output logic          out_valid,
    output payload_t      q
);

    always_ff @(posedge clk) begin
        if (rst || flush) begin // Flush wins over stall
            q         <= '0;
            out_valid <= 1'b0;
        end else if (!stall) begin
            q         <= d;
            out_valid <= in_valid;
        end
    end

    a_stall_hold: assert property (
        @(posedge clk) (stall && !flush && !rst) |=> ($stable(q) && $stable(out_valid))
    ) else $error("stage contents changed during stall");

    a_flush_clear: assert property (
        @(posedge clk) flush |=> !out_valid
    ) else $error("valid survived a flush");

endmodule

`default_nettype wire

// File: instr_decode.sv
`timescale 1ns/1ns
`default_nettype none
`include "decode_settings.svh"

module instr_decode
    import decode_pkg::*;
(
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    in_valid,
    input  wire [`DATA_W-1:0]      instruction,
    input  wire [`DATA_W-1:0]      pc,
    input  wire                    stall,
    input  wire                    flush,
    output logic                   out_valid,
    output logic                   undefined_inst,
    output alu_op_t                alu_op,
    output alu_src_t               alu_src,
    output ext_t                   alu_imm_src,
    output mem_type_t              mem_type,
    output mem_size_t              mem_size,
    output logic [`REG_ADDR_W-1:0] wb_reg_dest,
    output logic                   wb_reg_en,
    output ext_t                   unsigned_flag,
    output branch_kind_t           branch_kind,
    output logic                   is_branch_al,
    output logic [`REG_ADDR_W-1:0] rs,
    output logic [`REG_ADDR_W-1:0] rt,
    output logic [`REG_ADDR_W-1:0] shamt,
    output logic [`DATA_W-1:0]     imm,
    output logic [`DATA_W-1:0]     link_addr
);

    wire [`OPCODE_W-1:0]   opcode;
    wire [`FUNCT_W-1:0]    funct;
    wire [`REG_ADDR_W-1:0] instr_rt;
    wire [`REG_ADDR_W-1:0] instr_rd;
    wire [`IMM_W-1:0]      imm16;
    wire                   is_branch;
    wire ctrl_word_t       ctrl_d;    // Filled field by field from the decoders
    wire operand_word_t    operand_d;
    ctrl_word_t            ctrl_q;
    operand_word_t         operand_q;

    assign opcode          = instruction[31:26];
    assign instr_rt        = instruction[20:16];
    assign instr_rd        = instruction[15:11];
    assign funct           = instruction[5:0];
    assign imm16           = instruction[15:0];
    assign operand_d.rs    = instruction[25:21];
    assign operand_d.rt    = instr_rt;
    assign operand_d.shamt = instruction[10:6];

    branch_decoder u_branch_decoder (
        .opcode       (opcode),
        .rt           (instr_rt),
        .funct        (funct),
        .is_branch    (is_branch),
        .is_branch_al (ctrl_d.is_branch_al),
        .branch_kind  (ctrl_d.branch_kind)
    );

    decoder_ctrl u_decoder_ctrl (
        .instruction    (instruction),
        .opcode         (opcode),
        .rt             (instr_rt),
        .rd             (instr_rd),
        .funct          (funct),
        .is_branch      (is_branch),
        .is_branch_al   (ctrl_d.is_branch_al),
        .undefined_inst (ctrl_d.undefined_inst),
        .alu_op         (ctrl_d.alu_op),
        .alu_src        (ctrl_d.alu_src),
        .alu_imm_src    (ctrl_d.alu_imm_src),
        .mem_type       (ctrl_d.mem_type),
        .mem_size       (ctrl_d.mem_size),
        .wb_reg_dest    (ctrl_d.wb_reg_dest),
        .wb_reg_en      (ctrl_d.wb_reg_en),
        .unsigned_flag  (ctrl_d.unsigned_flag)
    );

    imm_gen u_imm_gen (
        .imm16       (imm16),
        .pc          (pc),
        .alu_imm_src (ctrl_d.alu_imm_src),
        .alu_op      (ctrl_d.alu_op),
        .imm         (operand_d.imm),
        .link_addr   (operand_d.link_addr)
    );

    stage_reg #(.payload_t(ctrl_word_t)) ctrl_reg (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .stall     (stall),
        .flush     (flush),
        .d         (ctrl_d),
        .out_valid (out_valid),
        .q         (ctrl_q)
    );

    // Same strobes as ctrl_reg, so its valid copy is redundant
    stage_reg #(.payload_t(operand_word_t)) operand_reg (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .stall     (stall),
        .flush     (flush),
        .d         (operand_d),
        .out_valid (),
        .q         (operand_q)
    );

    assign undefined_inst = ctrl_q.undefined_inst;
    assign alu_op         = ctrl_q.alu_op;
    assign alu_src        = ctrl_q.alu_src;
    assign alu_imm_src    = ctrl_q.alu_imm_src;
    assign mem_type       = ctrl_q.mem_type;
    assign mem_size       = ctrl_q.mem_size;
    assign wb_reg_dest    = ctrl_q.wb_reg_dest;
    assign wb_reg_en      = ctrl_q.wb_reg_en;
    assign unsigned_flag  = ctrl_q.unsigned_flag;
    assign branch_kind    = ctrl_q.branch_kind;
    assign is_branch_al   = ctrl_q.is_branch_al;
    assign rs             = operand_q.rs;
    assign rt             = operand_q.rt;
    assign shamt          = operand_q.shamt;
    assign imm            = operand_q.imm;
    assign link_addr      = operand_q.link_addr;

endmodule

`default_nettype wire

// File: tb_instr_decode.sv
`timescale 1ns/1ns
`default_nettype none
`include "decode_settings.svh"

module tb_instr_decode
    import decode_pkg::*;
();

    typedef struct packed {
        logic          valid;
        ctrl_word_t    c;
        operand_word_t o;
    } stage_t;

    localparam int NUM_CYCLES = 2000;
    localparam int MAX_CYCLES = NUM_CYCLES + 1000; // Stimulus length plus margin
    localparam logic [5:0] R_FUNCTS [28] = '{
        6'h20, 6'h21, 6'h22, 6'h23, 6'h2a, 6'h2b, 6'h1a, 6'h1b, 6'h18, 6'h19,
        6'h24, 6'h25, 6'h26, 6'h27, 6'h04, 6'h06, 6'h07, 6'h00, 6'h02, 6'h03,
        6'h10, 6'h12, 6'h11, 6'h13, 6'h0d, 6'h0c, 6'h08, 6'h09};
    localparam logic [5:0] MEM_OPS [8] = '{
        6'h20, 6'h21, 6'h23, 6'h24, 6'h25, 6'h28, 6'h29, 6'h2b};
    localparam logic [5:0] BR_OPS [8] = '{
        6'h04, 6'h05, 6'h06, 6'h07, 6'h02, 6'h03, 6'h01, 6'h01};

    logic               clk = 1'b0;
    logic               rst = 1'b1;
    logic               in_valid = 1'b0;
    logic [`DATA_W-1:0] instruction = '0;
    logic [`DATA_W-1:0] pc = '0;
    logic               stall = 1'b0;
    logic               flush = 1'b0;

    logic                   out_valid, undefined_inst, wb_reg_en, is_branch_al;
    alu_op_t                alu_op;
    alu_src_t               alu_src;
    ext_t                   alu_imm_src, unsigned_flag;
    mem_type_t              mem_type;
    mem_size_t              mem_size;
    branch_kind_t           branch_kind;
    logic [`REG_ADDR_W-1:0] wb_reg_dest, rs, rt, shamt;
    logic [`DATA_W-1:0]     imm, link_addr;
    ctrl_word_t             got_c;
    operand_word_t          got_o;

    integer seed = 75;
    integer cycles = 0;
    stage_t model;
    stage_t exp_q [$];   // Expected stage contents after the next edge
    string  grp_q [$];
    string  cur_grp;
    string  held_grp;

    instr_decode instr_decode_inst (.*);

    assign got_c = {undefined_inst, alu_op, alu_src, alu_imm_src, mem_type, mem_size,
                    wb_reg_dest, wb_reg_en, unsigned_flag, branch_kind, is_branch_al};
    assign got_o = {rs, rt, shamt, imm, link_addr};

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: test did not finish within %0d cycles", MAX_CYCLES);
            $display("STATUS: FAIL");
            $fatal(1, "timeout");
        end
    end

    task automatic check(input string name, input logic [79:0] expected,
                         input logic [79:0] actual);
        if (expected !== actual) begin
            $display("FAILED %s expected %h actual %h", name, expected, actual);
            $display("STATUS: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    // Expected decode of one word from the MIPS encoding
    function automatic stage_t ref_decode(input logic [31:0] w, input logic [31:0] p);
        stage_t     s;
        logic [5:0] op;
        logic [5:0] fn;
        logic       known;
        op = w[31:26];
        fn = w[5:0];
        known = 1'b1;
        s = '0;
        s.valid = 1'b1;
        s.c.alu_op = ALU_ADDU;
        s.c.mem_size = SZ_FULL;
        s.c.unsigned_flag = ZERO_EXTENDED;
        s.c.wb_reg_dest = w[20:16];
        s.c.alu_imm_src = (op inside {6'h0c, 6'h0d, 6'h0e, 6'h0f}) ? ZERO_EXTENDED :
                                                                     SIGN_EXTENDED;
        case (op)
            6'h04: s.c.branch_kind = BR_BEQ;
            6'h05: s.c.branch_kind = BR_BNE;
            6'h06: s.c.branch_kind = BR_BLEZ;
            6'h07: s.c.branch_kind = BR_BGTZ;
            6'h02, 6'h03: s.c.branch_kind = BR_J;
            6'h01: begin // REGIMM
                if (w[19:17] == 3'b000)
                    s.c.branch_kind = w[16] ? BR_BGEZ : BR_BLTZ;
            end
            6'h00: begin
                if (fn[5:1] == 5'b00100)
                    s.c.branch_kind = BR_JR;
            end
            default: ;
        endcase
        s.c.is_branch_al = s.c.branch_kind != BR_NONE &&
                           (op == 6'h03 || (op == 6'h01 && w[20]) || (op == 6'h00 && fn[0]));
        if (op == 6'h00) begin
            s.c.wb_reg_dest = w[15:11];
            s.c.alu_src = (fn[5:2] == 4'b0000) ? SRC_SFT : SRC_REG; // Constant shifts
            case (fn)
                6'h20: s.c.alu_op = ALU_ADD;
                6'h21: s.c.alu_op = ALU_ADDU;
                6'h22: s.c.alu_op = ALU_SUB;
                6'h23: s.c.alu_op = ALU_SUBU;
                6'h2a: s.c.alu_op = ALU_SLT;
                6'h2b: s.c.alu_op = ALU_SLTU;
                6'h1a: s.c.alu_op = ALU_DIV;
                6'h1b: s.c.alu_op = ALU_DIVU;
                6'h18: s.c.alu_op = ALU_MULT;
                6'h19: s.c.alu_op = ALU_MULTU;
                6'h24: s.c.alu_op = ALU_AND;
                6'h25: s.c.alu_op = ALU_OR;
                6'h26: s.c.alu_op = ALU_XOR;
                6'h27: s.c.alu_op = ALU_NOR;
                6'h00, 6'h04: s.c.alu_op = ALU_SLL;
                6'h02, 6'h06: s.c.alu_op = ALU_SRL;
                6'h03, 6'h07: s.c.alu_op = ALU_SRA;
                6'h10: s.c.alu_op = ALU_MFHI;
                6'h12: s.c.alu_op = ALU_MFLO;
                6'h11: s.c.alu_op = ALU_MTHI;
                6'h13: s.c.alu_op = ALU_MTLO;
                6'h0d: s.c.alu_op = ALU_BREK;
                6'h0c: s.c.alu_op = ALU_SYSC;
                default: known = 1'b0;
            endcase
        end else begin
            s.c.alu_src = SRC_IMM;
            case (op)
                6'h08: s.c.alu_op = ALU_ADD;
                6'h09: s.c.alu_op = ALU_ADDU;
                6'h0a: s.c.alu_op = ALU_SLT;
                6'h0b: s.c.alu_op = ALU_SLTU;
                6'h0c: s.c.alu_op = ALU_AND;
                6'h0d: s.c.alu_op = ALU_OR;
                6'h0e: s.c.alu_op = ALU_XOR;
                6'h0f: s.c.alu_op = ALU_LUI;
                6'h20, 6'h21, 6'h23, 6'h24, 6'h25, 6'h28, 6'h29, 6'h2b: begin
                    s.c.mem_type = op[3] ? MEM_STOR : MEM_LOAD;
                    s.c.mem_size = (op[1:0] == 2'b00) ? SZ_BYTE :
                                   (op[1:0] == 2'b01) ? SZ_HALF : SZ_FULL;
                    s.c.unsigned_flag = (op[3:1] == 3'b000) ? SIGN_EXTENDED : ZERO_EXTENDED;
                end
                6'h10: begin // COP0
                    s.c.alu_src = SRC_REG;
                    if (w == `ERET_WORD)
                        s.c.alu_op = ALU_ERET;
                    else if (w[25:21] == 5'b00000)
                        s.c.alu_op = ALU_MFC0;
                    else if (w[25:21] == 5'b00100)
                        s.c.alu_op = ALU_MTC0;
                    else
                        known = 1'b0;
                end
                default: known = 1'b0;
            endcase
        end
        s.c.wb_reg_en = known && s.c.mem_type != MEM_STOR &&
                        !(s.c.alu_op inside {ALU_DIV, ALU_DIVU, ALU_MULT, ALU_MULTU, ALU_MTHI,
                                             ALU_MTLO, ALU_BREK, ALU_SYSC, ALU_ERET, ALU_MTC0});
        if (!known) begin
            s.c.alu_src = SRC_REG;
            s.c.wb_reg_dest = w[20:16];
            s.c.undefined_inst = (s.c.branch_kind == BR_NONE);
        end
        if (!known && s.c.is_branch_al) begin // Return address into $ra
            s.c.alu_op = ALU_OUTA;
            s.c.alu_src = SRC_PCA;
            s.c.wb_reg_dest = `REG_RA;
            s.c.wb_reg_en = 1'b1;
        end
        s.o.rs = w[25:21];
        s.o.rt = w[20:16];
        s.o.shamt = w[10:6];
        if (s.c.alu_op == ALU_LUI)
            s.o.imm = {w[15:0], 16'h0000};
        else if (s.c.alu_imm_src == ZERO_EXTENDED)
            s.o.imm = {16'h0000, w[15:0]};
        else
            s.o.imm = {{16{w[15]}}, w[15:0]};
        s.o.link_addr = p + 32'd8;
        return s;
    endfunction

    task automatic pick_instr(output logic [31:0] w, output string g);
        logic [31:0] r;
        integer      sel;
        r = $random(seed);
        sel = {$random(seed)} % 12;
        if (sel < 3) begin
            g = "rtype";
            if (r[31:29] == 3'b000)
                w = {6'h00, r[25:0]}; // Any funct including undefined ones
            else
                w = {6'h00, r[25:6], R_FUNCTS[{$random(seed)} % 28]};
        end else if (sel < 5) begin
            g = "immediate";
            w = {3'b001, r[28:0]};
        end else if (sel < 7) begin
            g = "memory";
            w = {MEM_OPS[r[28:26]], r[25:0]};
        end else if (sel < 9) begin
            g = "branch";
            w = {BR_OPS[r[28:26]], r[25:20], 3'b000, r[16:0]};
        end else if (sel == 9) begin
            g = "privileged";
            case (r[31:30])
                2'd0: w = `ERET_WORD;
                2'd1: w = {6'h10, 5'h00, r[20:0]}; // MFC0
                2'd2: w = {6'h10, 5'h04, r[20:0]}; // MTC0
                default: w = {6'h10, r[25:0]};
            endcase
        end else begin
            g = "random";
            w = r;
        end
    endtask

    task automatic compare_stage();
        stage_t e;
        string  g;
        e = exp_q.pop_front();
        g = grp_q.pop_front();
        check({g, " out_valid"}, e.valid, out_valid);
        check({g, " cleared fields"}, {e.c.undefined_inst, e.c.wb_reg_en, e.c.mem_type},
              {undefined_inst, wb_reg_en, mem_type});
        if (e.valid) begin
            check({g, " ctrl word"}, e.c, got_c);
            check({g, " operand word"}, e.o, got_o);
        end
    endtask

    initial begin
        model = '0; // First edge is in reset
        held_grp = "reset";
        exp_q.push_back(model);
        grp_q.push_back(held_grp);
        for (int i = 0; i < NUM_CYCLES; i++) begin
            @(negedge clk);
            compare_stage();
            rst = (i < 2) || (i >= 1000 && i < 1003);
            if (!stall || flush) begin // Stalled word stays presented
                pick_instr(instruction, cur_grp);
                pc = $random(seed) & 32'hffff_fffc;
                in_valid = ({$random(seed)} % 8) != 0;
            end
            stall = ({$random(seed)} % 6) == 0;
            flush = ({$random(seed)} % 20) == 0;
            if (rst || flush) begin
                model = '0;
                held_grp = rst ? "reset" : "flush";
            end else if (!stall) begin
                model = ref_decode(instruction, pc);
                model.valid = in_valid;
                held_grp = cur_grp;
            end
            exp_q.push_back(model);
            grp_q.push_back(held_grp);
        end
        @(negedge clk);
        compare_stage();
        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: instr_decode.f
+incdir+.
decode_pkg.sv
branch_decoder.sv
decoder_ctrl.sv
imm_gen.sv
stage_reg.sv
instr_decode.sv
tb_instr_decode.sv

// File: Bender.yml
package:
  name: instr_decode

sources:
  - include_dirs:
      - .
    files:
      - decode_pkg.sv
      - branch_decoder.sv
      - decoder_ctrl.sv
      - imm_gen.sv
      - stage_reg.sv
      - instr_decode.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_instr_decode.sv
